/* fd_pkg.sv */
/*
 * Shared definitions for the FD1089 style decryption unit
 *   table address widths
 *   final variant and fetch kind enums
 *   bit order type and permute helper
 *   fixed constants of the substitution and final mix rows
 */
package fd_pkg;

    localparam int KEY_AW = 13;
    localparam int LUT_AW = 8;

    typedef enum logic {
        fd_variant_a = 1'b0,
        fd_variant_b = 1'b1
    } fd_variant_e;

    typedef enum logic {
        fd_access_op   = 1'b0,
        fd_access_data = 1'b1
    } fd_access_e;

    // Entry i names the source bit of result bit 7-i
    typedef logic [2:0] fd_perm_t [8];

    function automatic logic [7:0] fd_permute(input logic [7:0] v, input fd_perm_t p);
        logic [7:0] r;
        for (int i = 0; i < 8; i++) begin
            r[7-i] = v[p[i]];
        end
        return r;
    endfunction

    // Rows applied to the encrypted byte, selected by key bits 7 to 4
    localparam logic [7:0] fd_second_xor [16] = '{
        8'h23, 8'h92, 8'hb8, 8'h74, 8'hcf, 8'hc4, 8'h51, 8'h14,
        8'h7f, 8'h03, 8'h96, 8'h30, 8'he2, 8'h72, 8'hf5, 8'h5b
    };

    localparam fd_perm_t fd_second_perm [16] = '{
        '{6, 4, 5, 7, 3, 0, 1, 2},
        '{2, 5, 3, 6, 7, 1, 0, 4},
        '{6, 7, 4, 2, 0, 5, 1, 3},
        '{5, 3, 7, 1, 4, 6, 0, 2},
        '{7, 4, 1, 0, 6, 2, 3, 5},
        '{3, 1, 6, 4, 5, 0, 2, 7},
        '{5, 7, 2, 4, 3, 1, 6, 0},
        '{7, 2, 0, 6, 1, 3, 4, 5},
        '{3, 5, 6, 0, 2, 1, 7, 4},
        '{2, 3, 4, 0, 6, 7, 5, 1},
        '{3, 1, 7, 5, 2, 4, 6, 0},
        '{7, 6, 2, 3, 0, 4, 5, 1},
        '{1, 0, 3, 7, 4, 5, 2, 6},
        '{1, 6, 0, 5, 7, 2, 4, 3},
        '{0, 4, 1, 2, 6, 5, 7, 3},
        '{0, 7, 5, 3, 1, 4, 2, 6}
    };

    // Variant A family rows, xor first and then reorder
    localparam logic [7:0] fd_last_xor [16] = '{
        8'h55, 8'h94, 8'h8d, 8'h9a, 8'h72, 8'hff, 8'h06, 8'hc5,
        8'hec, 8'h89, 8'h5c, 8'h3f, 8'h57, 8'hf7, 8'h3a, 8'hac
    };

    localparam fd_perm_t fd_last_perm [16] = '{
        '{6, 5, 1, 0, 7, 4, 2, 3},
        '{7, 6, 4, 2, 0, 5, 1, 3},
        '{1, 4, 2, 3, 0, 6, 7, 5},
        '{4, 3, 5, 6, 0, 2, 1, 7},
        '{4, 3, 7, 0, 5, 6, 1, 2},
        '{1, 7, 2, 3, 6, 4, 5, 0},
        '{6, 5, 3, 2, 4, 1, 0, 7},
        '{3, 5, 1, 4, 2, 7, 0, 6},
        '{4, 7, 5, 1, 6, 0, 2, 3},
        '{3, 5, 0, 6, 1, 2, 7, 4},
        '{1, 3, 0, 7, 5, 2, 4, 6},
        '{7, 3, 0, 2, 4, 6, 1, 5},
        '{6, 4, 7, 2, 1, 5, 3, 0},
        '{6, 3, 7, 0, 5, 4, 2, 1},
        '{6, 1, 3, 2, 7, 4, 5, 0},
        '{1, 6, 3, 5, 0, 7, 4, 2}
    };

endpackage

/* fd_stage_if.sv */
/*
 * Pipeline buses of the decryption unit
 *   fd_key_if   decode to execute
 *   fd_byte_if  execute to result
 */
`timescale 1ns/1ns

interface fd_key_if import fd_pkg::*; ();
    logic              valid;
    fd_access_e        access;
    fd_variant_e       variant;
    logic              apply;
    logic [15:0]       enc;
    logic [7:0]        key;
    logic [LUT_AW-1:0] lut_addr;

    modport src (
        output valid, access, variant, apply, enc, key, lut_addr
    );

    modport dst (
        input valid, access, variant, apply, enc, key, lut_addr
    );
endinterface

interface fd_byte_if ();
    logic        valid;
    logic        apply;
    logic [15:0] enc;
    logic [7:0]  dec_byte;

    modport src (
        output valid, apply, enc, dec_byte
    );

    modport dst (
        input valid, apply, enc, dec_byte
    );
endinterface

/* fd_table_ram.sv */
/*
 * Byte wide table memory
 * One write port, registered read port
 */
`timescale 1ns/1ns

module fd_table_ram #(
    parameter int AW = 8
) (
    input  logic          clk,
    input  logic          we,
    input  logic [AW-1:0] wr_addr,
    input  logic [7:0]    wr_data,
    input  logic [AW-1:0] rd_addr,
    output logic [7:0]    q
);
    logic [7:0] mem [1 << AW];

    // Read before write on a shared address
    always_ff @(posedge clk) begin
        if (we) begin
            mem[wr_addr] <= wr_data;
        end
        q <= mem[rd_addr];
    end

endmodule

/* fd_key_decode.sv */
/*
 * Decode stage
 *   key table lookup from fetch kind and address
 *   key unshuffle for opcode and data fetches
 *   substitution table address from the encrypted byte
 */
`timescale 1ns/1ns

module fd_key_decode import fd_pkg::*; #(
    parameter int KEY_AW = fd_pkg::KEY_AW
) (
    input  logic              clk,
    input  logic              rst_n,
    input  logic              req,
    input  fd_access_e        access,
    input  logic [23:1]       addr,
    input  logic [15:0]       enc,
    input  fd_variant_e       variant,
    input  logic              dec_en,
    input  logic [KEY_AW-1:0] prog_addr,
    input  logic [7:0]        prog_data,
    input  logic              key_we,
    fd_key_if.src             out
);
    logic [KEY_AW-1:0] key_addr;
    logic [7:0]        key_raw;
    logic [7:0]        key_mix;
    logic [7:0]        enc_byte;
    logic [7:0]        sub_addr;
    logic              valid_q;
    fd_access_e        access_q;
    fd_variant_e       variant_q;
    logic              dec_en_q;
    logic [15:0]       enc_q;

    assign key_addr = {access, addr[23:16], addr[9], addr[5], addr[3], addr[1]};

    fd_table_ram #(
        .AW (KEY_AW)
    ) u_key_ram (
        .clk     (clk),
        .we      (key_we),
        .wr_addr (prog_addr),
        .wr_data (prog_data),
        .rd_addr (key_addr),
        .q       (key_raw)
    );

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            valid_q <= 1'b0;
        end else begin
            valid_q <= req;
        end
    end

    // Request fields line up with the key byte
    always_ff @(posedge clk) begin
        access_q  <= access;
        variant_q <= variant;
        dec_en_q  <= dec_en;
        enc_q     <= enc;
    end

    always_comb begin
        key_mix = key_raw;
        if (access_q == fd_access_data) begin
            key_mix[5:4] = ~key_mix[5:4];
            if (!key_mix[3]) begin
                key_mix[1] = ~key_mix[1];
            end
            key_mix = {key_mix[1], key_mix[0], key_mix[6], key_mix[4],
                       key_mix[3], key_mix[5], key_mix[2], key_mix[7]};
            if (key_mix[6]) begin
                key_mix = {key_mix[7:6], key_mix[2], key_mix[4],
                           key_mix[5], key_mix[3], key_mix[1:0]};
            end
        end else begin
            key_mix[4:2] = ~key_mix[4:2];
            if (!key_mix[3]) begin
                key_mix[5] = ~key_mix[5];
            end
            if (key_mix[7]) begin
                key_mix[6] = ~key_mix[6];
            end
            key_mix = {key_mix[5], key_mix[7], key_mix[6], key_mix[4],
                       key_mix[2], key_mix[3], key_mix[1:0]};
            if (key_mix[6]) begin
                key_mix = {key_mix[7:5], key_mix[3], key_mix[2],
                           key_mix[4], key_mix[1:0]};
            end
        end
        // Common fold of bits 5 and 4
        if (key_mix[6]) begin
            key_mix[4] = key_mix[4] ^ key_mix[5];
        end else begin
            key_mix[5] = key_mix[5] ^ ~key_mix[4];
        end
    end

    assign enc_byte = {enc_q[15:10], enc_q[6], enc_q[3]};

    always_comb begin
        sub_addr = fd_permute(enc_byte, fd_second_perm[key_mix[7:4]])
                   ^ fd_second_xor[key_mix[7:4]];
        if (key_mix[3]) begin
            sub_addr[0] = ~sub_addr[0];
        end
        if (key_mix[0]) begin
            sub_addr = sub_addr ^ 8'hb1;
        end
        if (access_q == fd_access_op) begin
            sub_addr = sub_addr ^ 8'h34;
        end else begin
            sub_addr[0] = sub_addr[0] ^ key_mix[6];
        end
    end

    assign out.valid    = valid_q;
    assign out.access   = access_q;
    assign out.variant  = variant_q;
    assign out.apply    = dec_en_q && (key_raw != 8'h00);
    assign out.enc      = enc_q;
    assign out.key      = key_mix;
    assign out.lut_addr = sub_addr;

    // Programming and decryption are separate phases
    assert property (@(posedge clk) disable iff (!rst_n) !(req && key_we))
        else $error("key table write collides with a request");

endmodule

/* fd_byte_execute.sv */
/*
 * Execute stage
 *   substitution table read
 *   variant A family rows or variant B nibble swaps
 */
`timescale 1ns/1ns

module fd_byte_execute import fd_pkg::*; #(
    parameter int LUT_AW = fd_pkg::LUT_AW
) (
    input  logic              clk,
    input  logic              rst_n,
    input  logic [LUT_AW-1:0] prog_addr,
    input  logic [7:0]        prog_data,
    input  logic              lut_we,
    fd_key_if.dst             in,
    fd_byte_if.src            out
);
    logic [7:0]  preval;
    logic        valid_q;
    logic        apply_q;
    logic [15:0] enc_q;
    logic [7:0]  key_q;
    fd_access_e  access_q;
    fd_variant_e variant_q;
    logic        fam_top;
    logic [3:0]  family;
    logic [7:0]  last_in;
    logic [7:0]  val_a;
    logic [7:0]  val_b;

    fd_table_ram #(
        .AW (LUT_AW)
    ) u_lut_ram (
        .clk     (clk),
        .we      (lut_we),
        .wr_addr (prog_addr),
        .wr_data (prog_data),
        .rd_addr (in.lut_addr),
        .q       (preval)
    );

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            valid_q <= 1'b0;
        end else begin
            valid_q <= in.valid;
        end
    end

    always_ff @(posedge clk) begin
        apply_q   <= in.apply;
        enc_q     <= in.enc;
        key_q     <= in.key;
        access_q  <= in.access;
        variant_q <= in.variant;
    end

    // Shared by the family code and the variant B low bit
    assign fam_top = (access_q == fd_access_data) ? (key_q[4] ^ (~key_q[6] & key_q[2]))
                                                  : (key_q[5] ^ (key_q[6] & key_q[2]));
    assign family  = {fam_top, key_q[2:0]};

    always_comb begin
        last_in = preval;
        if (key_q[0]) begin
            if (last_in[0]) begin
                last_in[7:6] = ~last_in[7:6];
            end
            if (~last_in[6] ^ last_in[4]) begin
                last_in = {last_in[7:4], last_in[1], last_in[0], last_in[2], last_in[3]};
            end
        end else if (~last_in[6] ^ last_in[4]) begin
            last_in = {last_in[7:4], last_in[0], last_in[1], last_in[3], last_in[2]};
        end
        if (!last_in[6]) begin
            last_in = {last_in[7:4], last_in[2], last_in[3], last_in[0], last_in[1]};
        end
        val_a = fd_permute(last_in ^ fd_last_xor[family], fd_last_perm[family]);
    end

    always_comb begin
        val_b    = preval;
        val_b[0] = val_b[0] ^ fam_top;
        if (key_q[2]) begin
            val_b = {val_b[7:4], val_b[1:0], val_b[3:2]};
            if (key_q[0] ^ key_q[1]) begin
                val_b = {val_b[7:4], val_b[0], val_b[1], val_b[3], val_b[2]};
            end
        end else begin
            val_b = {val_b[7:4], val_b[3:2], val_b[0], val_b[1]};
            if (key_q[0] ^ key_q[1]) begin
                val_b = {val_b[7:4], val_b[1], val_b[0], val_b[2], val_b[3]};
            end
        end
    end

    assign out.valid    = valid_q;
    assign out.apply    = apply_q;
    assign out.enc      = enc_q;
    assign out.dec_byte = (variant_q == fd_variant_b) ? val_b : val_a;

    // Substitution table must be stable while a word reads it
    assert property (@(posedge clk) disable iff (!rst_n) !(lut_we && in.valid))
        else $error("substitution table write while a word is in flight");

endmodule

/* fd_word_result.sv */
/*
 * Result stage
 * Merges the decrypted byte back into the word and registers it
 */
`timescale 1ns/1ns

module fd_word_result (
    input  logic        clk,
    input  logic        rst_n,
    fd_byte_if.dst      in,
    output logic [15:0] dec,
    output logic        dec_valid
);
    logic [15:0] word;

    // Encrypted field sits at bits 15 to 10, 6 and 3
    always_comb begin
        word = in.enc;
        if (in.apply) begin
            word[15:10] = in.dec_byte[7:2];
            word[6]     = in.dec_byte[1];
            word[3]     = in.dec_byte[0];
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            dec       <= 16'h0000;
            dec_valid <= 1'b0;
        end else begin
            dec_valid <= in.valid;
            if (in.valid) begin
                dec <= word;
            end
        end
    end

    assert property (@(posedge clk) disable iff (!rst_n) dec_valid |-> !$isunknown(dec))
        else $error("dec_valid with unknown bits in dec");

endmodule

/* fd_decrypt_top.sv */
/*
 * FD1089 style fetch decryption, three stage pipeline
 * Decode, execute and result stages joined by two buses
 */
`timescale 1ns/1ns

module fd_decrypt_top import fd_pkg::*; #(
    parameter int KEY_AW = fd_pkg::KEY_AW,
    parameter int LUT_AW = fd_pkg::LUT_AW
) (
    input  logic              clk,
    input  logic              rst_n,
    input  logic [KEY_AW-1:0] prog_addr,
    input  logic [7:0]        prog_data,
    input  logic              key_we,
    input  logic              lut_we,
    input  logic              req,
    input  fd_access_e        access,
    input  logic [23:1]       addr,
    input  logic [15:0]       enc,
    input  fd_variant_e       variant,
    input  logic              dec_en,
    output logic [15:0]       dec,
    output logic              dec_valid
);
    fd_key_if  key_bus ();
    fd_byte_if byte_bus ();

    fd_key_decode #(
        .KEY_AW (KEY_AW)
    ) u_decode (
        .clk       (clk),
        .rst_n     (rst_n),
        .req       (req),
        .access    (access),
        .addr      (addr),
        .enc       (enc),
        .variant   (variant),
        .dec_en    (dec_en),
        .prog_addr (prog_addr),
        .prog_data (prog_data),
        .key_we    (key_we),
        .out       (key_bus.src)
    );

    fd_byte_execute #(
        .LUT_AW (LUT_AW)
    ) u_execute (
        .clk       (clk),
        .rst_n     (rst_n),
        .prog_addr (prog_addr[LUT_AW-1:0]),
        .prog_data (prog_data),
        .lut_we    (lut_we),
        .in        (key_bus.dst),
        .out       (byte_bus.src)
    );

    fd_word_result u_result (
        .clk       (clk),
        .rst_n     (rst_n),
        .in        (byte_bus.dst),
        .dec       (dec),
        .dec_valid (dec_valid)
    );

endmodule

/* fd_ref_model.svh */
/*
 * Reference decryption of one fetch word
 * Works from copies of the key and substitution tables
 * and the fixed rows of fd_pkg
 */
`ifndef FD_REF_MODEL_SVH
`define FD_REF_MODEL_SVH

function automatic logic [15:0] fd_ref_decrypt(
    input logic [7:0]          key_mem [1 << fd_pkg::KEY_AW],
    input logic [7:0]          lut_mem [1 << fd_pkg::LUT_AW],
    input fd_pkg::fd_access_e  access,
    input logic [23:1]         addr,
    input logic [15:0]         enc,
    input fd_pkg::fd_variant_e variant,
    input logic                dec_en
);
    logic [7:0]  k;
    logic [7:0]  a;
    logic [7:0]  b;
    logic        data;
    logic        top;
    logic [3:0]  fam;
    logic [15:0] word;
    data = (access == fd_pkg::fd_access_data);
    k    = key_mem[{access, addr[23:16], addr[9], addr[5], addr[3], addr[1]}];
    word = enc;
    if (!dec_en || k == 8'h00) begin
        return word;
    end
    // Key unshuffle
    if (data) begin
        k[5:4] = ~k[5:4];
        k[1]   = k[1] ^ ~k[3];
        k      = {k[1], k[0], k[6], k[4], k[3], k[5], k[2], k[7]};
        k      = k[6] ? {k[7:6], k[2], k[4], k[5], k[3], k[1:0]} : k;
    end else begin
        k[4:2] = ~k[4:2];
        k[5]   = k[5] ^ ~k[3];
        k[6]   = k[6] ^ k[7];
        k      = {k[5], k[7], k[6], k[4], k[2], k[3], k[1:0]};
        k      = k[6] ? {k[7:5], k[3], k[2], k[4], k[1:0]} : k;
    end
    if (k[6]) begin
        k[4] = k[4] ^ k[5];
    end else begin
        k[5] = k[5] ^ ~k[4];
    end
    // Substitution address and table byte
    a = {enc[15:10], enc[6], enc[3]};
    a = fd_pkg::fd_permute(a, fd_pkg::fd_second_perm[k[7:4]]) ^ fd_pkg::fd_second_xor[k[7:4]];
    a = a ^ {7'd0, k[3]} ^ (k[0] ? 8'hb1 : 8'h00);
    a = data ? (a ^ {7'd0, k[6]}) : (a ^ 8'h34);
    b = lut_mem[a];
    top = data ? (k[4] ^ (~k[6] & k[2])) : (k[5] ^ (k[6] & k[2]));
    if (variant == fd_pkg::fd_variant_a) begin
        if (k[0] && b[0]) begin
            b[7:6] = ~b[7:6];
        end
        if (~b[6] ^ b[4]) begin
            b = k[0] ? {b[7:4], b[1], b[0], b[2], b[3]} : {b[7:4], b[0], b[1], b[3], b[2]};
        end
        if (!b[6]) begin
            b = {b[7:4], b[2], b[3], b[0], b[1]};
        end
        fam = {top, k[2:0]};
        b   = fd_pkg::fd_permute(b ^ fd_pkg::fd_last_xor[fam], fd_pkg::fd_last_perm[fam]);
    end else begin
        b[0] = b[0] ^ top;
        b    = k[2] ? {b[7:4], b[1:0], b[3:2]} : {b[7:4], b[3:2], b[0], b[1]};
        if (k[0] ^ k[1]) begin
            b = k[2] ? {b[7:4], b[0], b[1], b[3], b[2]} : {b[7:4], b[1], b[0], b[2], b[3]};
        end
    end
    word[15:10] = b[7:2];
    word[6]     = b[1];
    word[3]     = b[0];
    return word;
endfunction

`endif

/* fd_decrypt_tb.sv */
/*
 * Testbench for the FD1089 style decryption unit
 *   clock, reset and table loading through the programming port
 *   LCG stimulus for bypass, variant A, variant B and burst tests
 *   compare process with latency and valid count checks
 */
`timescale 1ns/1ns

module fd_decrypt_tb import fd_pkg::*; ();
    localparam logic [15:0] FIELD_MASK = 16'hfc48;

    logic                clk;
    logic                rst_n;
    logic [KEY_AW-1:0]   prog_addr;
    logic [7:0]          prog_data;
    logic                key_we;
    logic                lut_we;
    logic                req;
    fd_access_e          access;
    logic [23:1]         addr;
    logic [15:0]         enc;
    fd_variant_e         variant;
    logic                dec_en;
    logic [15:0]         dec;
    logic                dec_valid;

    logic [7:0]          key_copy [1 << KEY_AW];
    logic [7:0]          lut_copy [1 << LUT_AW];
    logic [31:0]         lcg_state;
    int                  cyc;
    int                  sent;
    int                  valid_cycles;
    string               name_q [$];
    logic [15:0]         exp_q [$];
    logic [15:0]         enc_q [$];
    int                  stamp_q [$];

    `include "fd_ref_model.svh"

    fd_decrypt_top #(
        .KEY_AW (KEY_AW),
        .LUT_AW (LUT_AW)
    ) dut (
        .clk       (clk),
        .rst_n     (rst_n),
        .prog_addr (prog_addr),
        .prog_data (prog_data),
        .key_we    (key_we),
        .lut_we    (lut_we),
        .req       (req),
        .access    (access),
        .addr      (addr),
        .enc       (enc),
        .variant   (variant),
        .dec_en    (dec_en),
        .dec       (dec),
        .dec_valid (dec_valid)
    );

    always #5 clk = ~clk;

    always @(posedge clk) begin
        cyc <= cyc + 1;
    end

    function automatic logic [31:0] rand32();
        lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
        return lcg_state;
    endfunction

    task automatic report_failure(input string what);
        $display("%s", what);
        $display("Simulation FAILED");
        $fatal(1, "stopping at first error");
    endtask

    task automatic check_value(input string name, input logic [31:0] expected,
                               input logic [31:0] actual);
        if (expected !== actual) begin
            report_failure($sformatf("Fail %s: expected %0h, actual %0h",
                                     name, expected, actual));
        end
    endtask

    task automatic write_table(input logic is_key, input logic [KEY_AW-1:0] a,
                               input logic [7:0] d);
        @(posedge clk);
        prog_addr <= a;
        prog_data <= d;
        key_we    <= is_key;
        lut_we    <= !is_key;
    endtask

    task automatic pick_request(output fd_access_e acc, output logic [23:1] a,
                                output logic [15:0] e, output fd_variant_e v);
        logic [31:0] r;
        r   = rand32();
        acc = fd_access_e'(r[31]);
        v   = fd_variant_e'(r[30]);
        e   = r[23:8];
        r   = rand32();
        a   = r[31:9];
    endtask

    // Output is due at the negedge after the third edge past the drive edge
    task automatic send_word(input string name, input fd_access_e acc, input logic [23:1] a,
                             input logic [15:0] e, input fd_variant_e v, input logic en,
                             input logic [15:0] exp_word);
        @(posedge clk);
        req     <= 1'b1;
        access  <= acc;
        addr    <= a;
        enc     <= e;
        variant <= v;
        dec_en  <= en;
        name_q.push_back(name);
        exp_q.push_back(exp_word);
        enc_q.push_back(e);
        stamp_q.push_back(cyc + 4);
        sent++;
    endtask

    task automatic idle_cycle();
        @(posedge clk);
        req <= 1'b0;
    endtask

    initial begin : compare_words
        string       name;
        logic [15:0] exp_word;
        logic [15:0] enc_word;
        int          stamp;
        forever begin
            @(negedge clk);
            if (dec_valid && exp_q.size() == 0) begin
                report_failure("dec_valid went high with no request pending");
            end else if (dec_valid) begin
                valid_cycles++;
                name     = name_q.pop_front();
                exp_word = exp_q.pop_front();
                enc_word = enc_q.pop_front();
                stamp    = stamp_q.pop_front();
                check_value({name, " latency"}, stamp, cyc);
                check_value(name, exp_word, dec);
                check_value({name, " fixed bits"}, enc_word & ~FIELD_MASK, dec & ~FIELD_MASK);
            end else if (sent == 0) begin
                check_value("reset", 32'h0, dec);
            end
        end
    end

    initial begin : run_tests
        fd_access_e  acc;
        logic [23:1] a;
        logic [15:0] e;
        fd_variant_e v;
        logic [7:0]  kb;
        int          wait_cycles;
        clk = 1'b0;
        rst_n = 1'b0;
        prog_addr = '0;
        prog_data = 8'h00;
        key_we = 1'b0;
        lut_we = 1'b0;
        req = 1'b0;
        access = fd_access_op;
        addr = '0;
        enc = 16'h0000;
        variant = fd_variant_a;
        dec_en = 1'b0;
        lcg_state = 32'd19;
        cyc = 0;
        sent = 0;
        valid_cycles = 0;
        repeat (10) @(posedge clk);
        rst_n <= 1'b1;

        // Key bytes are zero wherever the low five address bits equal 7
        for (int i = 0; i < (1 << KEY_AW); i++) begin
            kb = rand32() >> 24;
            if (i[4:0] == 5'd7) begin
                kb = 8'h00;
            end else if (kb == 8'h00) begin
                kb = 8'h01;
            end
            key_copy[i] = kb;
            write_table(1'b1, i, kb);
        end
        for (int i = 0; i < (1 << LUT_AW); i++) begin
            lut_copy[i] = rand32() >> 24;
            write_table(1'b0, i, lut_copy[i]);
        end
        @(posedge clk);
        key_we <= 1'b0;
        lut_we <= 1'b0;
        repeat (3) @(posedge clk);

        for (int i = 0; i < 32; i++) begin
            pick_request(acc, a, e, v);
            send_word("disabled", acc, a, e, v, 1'b0, e);
            idle_cycle();
        end
        for (int i = 0; i < 32; i++) begin
            pick_request(acc, a, e, v);
            a[16] = 1'b0;
            a[9]  = 1'b0;
            a[5]  = 1'b1;
            a[3]  = 1'b1;
            a[1]  = 1'b1;
            send_word("zero_key", acc, a, e, v, 1'b1, e);
            idle_cycle();
        end
        for (int i = 0; i < 64; i++) begin
            pick_request(acc, a, e, v);
            send_word("variant_a", acc, a, e, fd_variant_a, 1'b1,
                      fd_ref_decrypt(key_copy, lut_copy, acc, a, e, fd_variant_a, 1'b1));
            idle_cycle();
        end
        for (int i = 0; i < 64; i++) begin
            pick_request(acc, a, e, v);
            send_word("variant_b", acc, a, e, fd_variant_b, 1'b1,
                      fd_ref_decrypt(key_copy, lut_copy, acc, a, e, fd_variant_b, 1'b1));
            idle_cycle();
        end
        // Back to back, one word per cycle
        for (int i = 0; i < 64; i++) begin
            pick_request(acc, a, e, v);
            send_word("burst", acc, a, e, v, 1'b1,
                      fd_ref_decrypt(key_copy, lut_copy, acc, a, e, v, 1'b1));
        end
        idle_cycle();

        wait_cycles = 0;
        while (exp_q.size() != 0 && wait_cycles < 50) begin
            @(posedge clk);
            wait_cycles++;
        end
        repeat (5) @(posedge clk);
        if (exp_q.size() != 0) begin
            report_failure("timed out waiting for the pipeline to drain");
        end else begin
            check_value("valid count", sent, valid_cycles);
            $display("Simulation PASSED");
            $finish;
        end
    end

endmodule

/* vlog.f */
+incdir+.
fd_pkg.sv
fd_stage_if.sv
fd_table_ram.sv
fd_key_decode.sv
fd_byte_execute.sv
fd_word_result.sv
fd_decrypt_top.sv
fd_decrypt_tb.sv

/* Bender.yml */
package:
  name: fd_decrypt

sources:
  - fd_pkg.sv
  - fd_stage_if.sv
  - fd_table_ram.sv
  - fd_key_decode.sv
  - fd_byte_execute.sv
  - fd_word_result.sv
  - fd_decrypt_top.sv
  - target: test
    include_dirs:
      - .
    files:
      - fd_decrypt_tb.sv
